/* hdl/img_pkg.sv */
package img_pkg;

  // Frame geometry.
  localparam int COLS = 8;
  localparam int ROWS = 8;

  // Ring of neighbours around a 3x3 centre.
  localparam int NEIGHBOURS = 8;

  // Interior windows per frame.
  localparam int WINDOWS = (COLS - 2) * (ROWS - 2);

  // Grayscale intensity.
  typedef logic [7:0] pixel_t;

  // Position in the frame.
  typedef logic [2:0] col_t;
  typedef logic [2:0] row_t;

endpackage

/* hdl/hist_pkg.sv */
package hist_pkg;

  // NI and RD both run 0..8.
  typedef logic [3:0] code_t;

  localparam int CODE_LEVELS = 9;
  localparam int NUM_BINS    = CODE_LEVELS * CODE_LEVELS;

  // Bin number is NI * 9 + RD.
  typedef logic [6:0] bin_idx_t;

  // Per-bin window count.
  typedef logic [7:0] count_t;

  // Absolute difference above this counts toward RD.
  localparam int RD_THRESH = 16;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_DUMP,
    RD_DONE
  } read_state_t;

endpackage

/* hdl/window_if.sv */
`timescale 1ns/1ps

interface window_if;

  img_pkg::pixel_t centre;
  // Index 0 is top-left, then clockwise.
  img_pkg::pixel_t [img_pkg::NEIGHBOURS-1:0] nb;
  logic win_valid;
  logic win_last; // Last interior window of the frame.

  modport src (
    output centre,
    output nb,
    output win_valid,
    output win_last
  );

  modport dst (
    input centre,
    input nb,
    input win_valid,
    input win_last
  );

endinterface

/* hdl/window_gen.sv */
`timescale 1ns/1ps

module window_gen (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  img_pkg::pixel_t pixel_i,
  input  logic            pixel_valid_i,
  window_if.src           win
);

  img_pkg::pixel_t line1_q [img_pkg::COLS]; // Previous row.
  img_pkg::pixel_t line2_q [img_pkg::COLS]; // Two rows back.
  img_pkg::pixel_t win_q [3][3]; // [row][col], col 2 is newest.
  img_pkg::col_t   col_q;
  img_pkg::row_t   row_q;
  logic            valid_q;
  logic            last_q;
  logic            interior;
  logic            last_px;

  assign interior = (row_q >= img_pkg::row_t'(2)) && (col_q >= img_pkg::col_t'(2));
  assign last_px  = (row_q == img_pkg::row_t'(img_pkg::ROWS - 1)) &&
                    (col_q == img_pkg::col_t'(img_pkg::COLS - 1));

  // Line buffers and window shift.
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      line2_q[col_q] <= line1_q[col_q];
      line1_q[col_q] <= pixel_i;
      for (int r = 0; r < 3; r++) begin
        win_q[r][0] <= win_q[r][1];
        win_q[r][1] <= win_q[r][2];
      end
      win_q[0][2] <= line2_q[col_q];
      win_q[1][2] <= line1_q[col_q];
      win_q[2][2] <= pixel_i;
    end
  end

  // Position tracking and window strobes.
  always_ff @(posedge clk) begin
    if (!rst_n || start_i) begin
      col_q   <= '0;
      row_q   <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= pixel_valid_i && interior;
      last_q  <= pixel_valid_i && last_px;
      if (pixel_valid_i) begin
        if (col_q == img_pkg::col_t'(img_pkg::COLS - 1)) begin
          col_q <= '0;
          if (row_q == img_pkg::row_t'(img_pkg::ROWS - 1)) begin
            row_q <= '0;
          end else begin
            row_q <= row_q + img_pkg::row_t'(1);
          end
        end else begin
          col_q <= col_q + img_pkg::col_t'(1);
        end
      end
    end
  end

  assign win.centre    = win_q[1][1];
  assign win.nb[0]     = win_q[0][0];
  assign win.nb[1]     = win_q[0][1];
  assign win.nb[2]     = win_q[0][2];
  assign win.nb[3]     = win_q[1][2];
  assign win.nb[4]     = win_q[2][2];
  assign win.nb[5]     = win_q[2][1];
  assign win.nb[6]     = win_q[2][0];
  assign win.nb[7]     = win_q[1][0];
  assign win.win_valid = valid_q;
  assign win.win_last  = last_q;

  // A window is only ever completed by a pixel in row 2 or below.
  a_win_row: assert property (@(posedge clk) disable iff (!rst_n)
    win.win_valid |-> $past(row_q) >= img_pkg::row_t'(2));

endmodule

/* hdl/ni_encoder.sv */
`timescale 1ns/1ps

module ni_encoder (
  input  logic            clk,
  input  logic            rst_n,
  window_if.dst           win,
  output hist_pkg::code_t ni_o,
  output logic            ni_valid_o,
  output logic            last_o
);

  hist_pkg::code_t ni_next;

  // Neighbours at least as bright as the centre.
  always_comb begin
    ni_next = '0;
    for (int i = 0; i < img_pkg::NEIGHBOURS; i++) begin
      if (win.nb[i] >= win.centre) begin
        ni_next = ni_next + hist_pkg::code_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    ni_o <= ni_next; // Payload, qualified by ni_valid_o.
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ni_valid_o <= 1'b0;
      last_o     <= 1'b0;
    end else begin
      ni_valid_o <= win.win_valid;
      last_o     <= win.win_valid && win.win_last;
    end
  end

  a_ni_range: assert property (@(posedge clk) disable iff (!rst_n)
    ni_valid_o |-> ni_o <= hist_pkg::code_t'(img_pkg::NEIGHBOURS));

endmodule

/* hdl/rd_encoder.sv */
`timescale 1ns/1ps

module rd_encoder (
  input  logic            clk,
  input  logic            rst_n,
  window_if.dst           win,
  output hist_pkg::code_t rd_o,
  output logic            rd_valid_o
);

  img_pkg::pixel_t diff [img_pkg::NEIGHBOURS];
  hist_pkg::code_t rd_next;

  // Absolute difference per neighbour.
  always_comb begin
    for (int i = 0; i < img_pkg::NEIGHBOURS; i++) begin
      if (win.nb[i] > win.centre) begin
        diff[i] = win.nb[i] - win.centre;
      end else begin
        diff[i] = win.centre - win.nb[i];
      end
    end
  end

  always_comb begin
    rd_next = '0;
    for (int i = 0; i < img_pkg::NEIGHBOURS; i++) begin
      if (diff[i] > img_pkg::pixel_t'(hist_pkg::RD_THRESH)) begin
        rd_next = rd_next + hist_pkg::code_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_o <= rd_next;
  end

  // Same latency as the NI path.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= win.win_valid;
    end
  end

endmodule

/* hdl/joint_histogram.sv */
`timescale 1ns/1ps

module joint_histogram (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  hist_pkg::code_t  ni_i,
  input  hist_pkg::code_t  rd_i,
  input  logic             code_valid_i,
  input  logic             rd_valid_i,
  input  logic             last_i,
  input  logic             read_en_i,
  output hist_pkg::count_t bin_o,
  output logic             bin_valid_o,
  output logic             read_done_o,
  output logic             frame_done_o
);

  hist_pkg::count_t      cnt_q [hist_pkg::NUM_BINS];
  hist_pkg::bin_idx_t    wr_idx;
  hist_pkg::bin_idx_t    rd_idx_q;
  hist_pkg::bin_idx_t    sel_idx;
  hist_pkg::read_state_t state_q;
  logic                  last_q;
  logic                  load_bin;

  // NI is the major index.
  assign wr_idx = hist_pkg::bin_idx_t'(ni_i) * hist_pkg::bin_idx_t'(hist_pkg::CODE_LEVELS)
                + hist_pkg::bin_idx_t'(rd_i);

  always_ff @(posedge clk) begin
    if (!rst_n || start_i) begin
      for (int i = 0; i < hist_pkg::NUM_BINS; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (code_valid_i) begin
      cnt_q[wr_idx] <= cnt_q[wr_idx] + hist_pkg::count_t'(1);
    end
  end

  // Done one cycle after the last increment.
  always_ff @(posedge clk) begin
    if (!rst_n || start_i) begin
      last_q       <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      last_q       <= code_valid_i && last_i;
      frame_done_o <= last_q;
    end
  end

  // Bin 0 is loaded on the accepting edge.
  assign sel_idx  = (state_q == hist_pkg::RD_IDLE) ? '0 : rd_idx_q;
  assign load_bin = ((state_q == hist_pkg::RD_IDLE) && read_en_i) ||
                    (state_q == hist_pkg::RD_DUMP);

  always_ff @(posedge clk) begin
    if (load_bin) begin
      bin_o <= cnt_q[sel_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || start_i) begin
      state_q     <= hist_pkg::RD_IDLE;
      rd_idx_q    <= '0;
      bin_valid_o <= 1'b0;
      read_done_o <= 1'b0;
    end else begin
      read_done_o <= 1'b0;
      case (state_q)
        hist_pkg::RD_IDLE: begin
          if (read_en_i) begin
            state_q     <= hist_pkg::RD_DUMP;
            rd_idx_q    <= hist_pkg::bin_idx_t'(1);
            bin_valid_o <= 1'b1;
          end
        end
        hist_pkg::RD_DUMP: begin
          if (rd_idx_q == hist_pkg::bin_idx_t'(hist_pkg::NUM_BINS - 1)) begin
            state_q <= hist_pkg::RD_DONE; // Last bin is being loaded.
          end else begin
            rd_idx_q <= rd_idx_q + hist_pkg::bin_idx_t'(1);
          end
        end
        hist_pkg::RD_DONE: begin
          bin_valid_o <= 1'b0;
          read_done_o <= 1'b1;
          state_q     <= hist_pkg::RD_IDLE;
        end
        default: state_q <= hist_pkg::RD_IDLE;
      endcase
    end
  end

  // Both encoders see the same windows.
  a_valids_match: assert property (@(posedge clk) disable iff (!rst_n)
    code_valid_i == rd_valid_i);

  // A frame cannot fill a bin past its window count.
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || start_i)
    code_valid_i |-> cnt_q[wr_idx] < hist_pkg::count_t'(img_pkg::WINDOWS));

endmodule

/* hdl/texture_hist_top.sv */
`timescale 1ns/1ps

module texture_hist_top (
  input  logic             clk,
  input  logic             rst_n,
  input  img_pkg::pixel_t  pixel_i,
  input  logic             pixel_valid_i,
  input  logic             start_i,
  input  logic             read_en_i,
  output hist_pkg::count_t bin_o,
  output logic             bin_valid_o,
  output logic             read_done_o,
  output logic             frame_done_o
);

  hist_pkg::code_t ni;
  hist_pkg::code_t rd;
  logic            ni_valid;
  logic            rd_valid;
  logic            win_last;

  window_if win_bus ();

  window_gen u_window_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .win           (win_bus.src)
  );

  ni_encoder u_ni_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .win        (win_bus.dst),
    .ni_o       (ni),
    .ni_valid_o (ni_valid),
    .last_o     (win_last)
  );

  rd_encoder u_rd_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .win        (win_bus.dst),
    .rd_o       (rd),
    .rd_valid_o (rd_valid)
  );

  joint_histogram u_joint_histogram (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .ni_i         (ni),
    .rd_i         (rd),
    .code_valid_i (ni_valid), // NI strobe drives the increment.
    .rd_valid_i   (rd_valid),
    .last_i       (win_last),
    .read_en_i    (read_en_i),
    .bin_o        (bin_o),
    .bin_valid_o  (bin_valid_o),
    .read_done_o  (read_done_o),
    .frame_done_o (frame_done_o)
  );

endmodule

/* tests/tb_texture_hist.sv */
`timescale 1ns/1ps

module tb_texture_hist;

  localparam int K_CONST = 0;
  localparam int K_RAMP  = 1;
  localparam int K_CHECK = 2;
  localparam int K_LFSR  = 3;
  localparam int N_TESTS = 6;
  localparam int N_PIX   = img_pkg::COLS * img_pkg::ROWS;

  typedef struct packed {
    int   kind;
    int   base;
    logic mid_read; // Second read_en_i while the dump runs.
  } test_row_t;

  test_row_t tbl [N_TESTS] = '{
    '{K_CONST, 100, 1'b0},
    '{K_CHECK, 60, 1'b1},
    '{K_LFSR, 0, 1'b0},
    '{K_RAMP, 10, 1'b1},
    '{K_CONST, 200, 1'b0},
    '{K_LFSR, 0, 1'b1}
  };

  logic             clk;
  logic             rst_n;
  img_pkg::pixel_t  pixel_i;
  logic             pixel_valid_i;
  logic             start_i;
  logic             read_en_i;
  hist_pkg::count_t bin_o;
  logic             bin_valid_o;
  logic             read_done_o;
  logic             frame_done_o;

  int          frame [N_PIX];
  int          exp_hist [hist_pkg::NUM_BINS];
  logic [15:0] lfsr;
  int          errors;
  int          passed;

  texture_hist_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .start_i       (start_i),
    .read_en_i     (read_en_i),
    .bin_o         (bin_o),
    .bin_valid_o   (bin_valid_o),
    .read_done_o   (read_done_o),
    .frame_done_o  (frame_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #((N_TESTS * 250 + 100) * 10);
    $display("Timeout: the run did not finish within %0d clock periods.", N_TESTS * 250 + 100);
    $display("test failed");
    $finish;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic report_diff(input string name, input int exp, input int act);
    $display("mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
    errors++;
  endtask

  task automatic build_frame(input int kind, input int base);
    int idx;
    for (int r = 0; r < img_pkg::ROWS; r++) begin
      for (int c = 0; c < img_pkg::COLS; c++) begin
        idx = r * img_pkg::COLS + c;
        case (kind)
          K_RAMP:  frame[idx] = (base + 20 * c) % 256;
          K_CHECK: frame[idx] = ((r + c) % 2 == 1) ? base + 40 : base;
          K_LFSR: begin
            frame[idx] = 0;
            for (int b = 0; b < 8; b++) begin
              if (lfsr[0]) frame[idx] += (1 << b); // One step per bit.
              lfsr = lfsr_step(lfsr);
            end
          end
          default: frame[idx] = base;
        endcase
      end
    end
  endtask

  // Expected joint histogram over the interior windows.
  task automatic model_hist();
    int ni;
    int rd;
    int d;
    foreach (exp_hist[i]) exp_hist[i] = 0;
    for (int r = 1; r < img_pkg::ROWS - 1; r++) begin
      for (int c = 1; c < img_pkg::COLS - 1; c++) begin
        ni = 0;
        rd = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            if (dr != 0 || dc != 0) begin
              d = frame[(r + dr) * img_pkg::COLS + c + dc] - frame[r * img_pkg::COLS + c];
              if (d >= 0) ni++;
              if (d > hist_pkg::RD_THRESH || d < -hist_pkg::RD_THRESH) rd++;
            end
          end
        end
        exp_hist[ni * hist_pkg::CODE_LEVELS + rd]++;
      end
    end
  endtask

  task automatic send_frame(output int latency, output int done_count);
    latency    = 0;
    done_count = 0;
    start_i    = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    for (int i = 0; i < N_PIX; i++) begin
      if (frame_done_o) done_count++; // Early pulse.
      pixel_i       = img_pkg::pixel_t'(frame[i]);
      pixel_valid_i = 1'b1;
      @(negedge clk);
      pixel_valid_i = 1'b0;
      if (i % 7 == 3) begin
        if (frame_done_o) done_count++;
        @(negedge clk); // Idle gap.
      end
    end
    for (int k = 1; k <= 12; k++) begin
      if (frame_done_o) begin
        done_count++;
        if (latency == 0) latency = k;
      end
      @(negedge clk);
    end
  endtask

  task automatic read_bins(input logic mid_read);
    int   sum;
    logic exp_v;
    logic exp_d;
    sum       = 0;
    read_en_i = 1'b1;
    @(negedge clk);
    for (int k = 1; k <= 86; k++) begin
      read_en_i = mid_read && (k == 20);
      exp_v     = (k <= hist_pkg::NUM_BINS);
      exp_d     = (k == hist_pkg::NUM_BINS + 1);
      if (bin_valid_o !== exp_v) report_diff("bin_valid_o", exp_v, bin_valid_o);
      if (read_done_o !== exp_d) report_diff("read_done_o", exp_d, read_done_o);
      if (exp_v && bin_o !== hist_pkg::count_t'(exp_hist[k - 1])) begin
        report_diff($sformatf("bin_o[%0d]", k - 1), exp_hist[k - 1], bin_o);
      end
      if (exp_v) sum += bin_o;
      @(negedge clk);
    end
    if (sum != img_pkg::WINDOWS) begin
      $display("%0t: the bins add up to %0d windows instead of %0d", $time, sum,
               img_pkg::WINDOWS);
      errors++;
    end
  endtask

  initial begin
    int errs_before;
    int latency;
    int done_count;
    rst_n         = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    start_i       = 1'b0;
    read_en_i     = 1'b0;
    errors        = 0;
    passed        = 0;
    lfsr          = 16'd25;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Outputs idle after reset.
    if (bin_valid_o !== 1'b0) report_diff("bin_valid_o", 0, bin_valid_o);
    if (read_done_o !== 1'b0) report_diff("read_done_o", 0, read_done_o);
    if (frame_done_o !== 1'b0) report_diff("frame_done_o", 0, frame_done_o);
    for (int t = 0; t < N_TESTS; t++) begin
      errs_before = errors;
      build_frame(tbl[t].kind, tbl[t].base);
      model_hist();
      if (tbl[t].kind == K_CONST && exp_hist[72] != 36) begin
        $display("Reference model gives %0d windows in bin 72 of a flat frame", exp_hist[72]);
        errors++;
      end
      if (tbl[t].kind == K_CHECK && (exp_hist[40] != 18 || exp_hist[76] != 18)) begin
        $display("Reference model splits the checkerboard wrongly");
        errors++;
      end
      send_frame(latency, done_count);
      if (latency != 4) report_diff("frame_done_o delay", 4, latency);
      if (done_count != 1) report_diff("frame_done_o pulses", 1, done_count);
      read_bins(tbl[t].mid_read);
      if (errors == errs_before) begin
        passed++;
        $display("Test %0d (kind %0d, base %0d): ok", t, tbl[t].kind, tbl[t].base);
      end else begin
        $display("Test %0d (kind %0d, base %0d): %0d errors", t, tbl[t].kind, tbl[t].base,
                 errors - errs_before);
      end
    end
    $display("Summary: %0d of %0d tests ok, %0d errors", passed, N_TESTS, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* project.f */
hdl/img_pkg.sv
hdl/hist_pkg.sv
hdl/window_if.sv
hdl/window_gen.sv
hdl/ni_encoder.sv
hdl/rd_encoder.sv
hdl/joint_histogram.sv
hdl/texture_hist_top.sv
tests/tb_texture_hist.sv

/* Bender.yml */
package:
  name: texture_hist

sources:
  - hdl/img_pkg.sv
  - hdl/hist_pkg.sv
  - hdl/window_if.sv
  - hdl/window_gen.sv
  - hdl/ni_encoder.sv
  - hdl/rd_encoder.sv
  - hdl/joint_histogram.sv
  - hdl/texture_hist_top.sv
  - target: test
    files:
      - tests/tb_texture_hist.sv
